//--- list.f
wr_cfg_pkg.sv
wr_cmd_pkg.sv
wr_data_buffer.sv
wr_job_ctrl.sv
wr_cmd_issue.sv
wr_engine.sv
wr_engine_assert.sv
tb_wr_checker.sv
tb_wr_engine.sv

//--- Makefile
# Verilator flow for the write engine testbench
# override any variable on the command line, e.g. make sim TOP=tb_wr_engine

VERILATOR ?= verilator
TOP       ?= tb_wr_engine
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb_wr_engine.sv
////////////////////
// testbench for the write engine
// three jobs: mode set, mode cleared, mode set with command credits paused
// responses come back in command order after random delays
////////////////////

`timescale 1ns/1ps

module tb_wr_engine;

	import wr_cfg_pkg::*;
	import wr_cmd_pkg::*;

	localparam int BUF_DEPTH       = 8;
	localparam int CMD_CREDITS     = 4;
	localparam int MAX_OUTSTANDING = 6;
	localparam int NUM_JOBS        = 3;
	localparam int TOTAL_LINES     = 37 + 29 + 24;
	localparam int PAUSE_CYCLES    = 60;
	localparam int CYCLES_PER_ITEM = 40;
	localparam int WATCHDOG_CYCLES = TOTAL_LINES * CYCLES_PER_ITEM + PAUSE_CYCLES + 100;

	logic             clock;
	logic             rstn;
	wr_job_t          job;
	wr_data_t         data_in = '0;
	logic             cmd_credit = 1'b0;
	wr_resp_t         resp_in = '0;
	logic             data_credit;
	wr_cmd_t          cmd_out;
	wr_line_t         line_out;
	logic             job_busy;
	logic             job_done;
	logic [LEN_W-1:0] lines_done;

	wr_cmd_t           exp_cmd = '0;
	logic              report;
	int                errors;
	int                seed = 32'h535c;
	int                resp_seed = 32'h535c ^ 32'h0101;
	int                credit_seed = 32'h535c ^ 32'h0202;
	int                cycle = 0;
	int                credits = BUF_DEPTH;
	logic              credit_pause = 1'b0;
	wr_data_t          item_q[$];
	wr_cmd_t           ref_q[$];
	int                resp_due[$];
	logic [SIZE_W-1:0] resp_lines[$];
	int                credit_due[$];

	// expected command for one item of a job
	function automatic wr_cmd_t expect_cmd(wr_job_t j, wr_data_t d);
		wr_cmd_t c;
		c = '0;
		c.valid = 1'b1;
		c.op = j.mode ? op_write_ms : op_write_na;
		c.addr = j.base + (64'(d.offset) << 7);
		c.bytes = 12'(d.size) * 12'd128;
		c.lines = d.size;
		return c;
	endfunction

	function automatic logic [HALF_W-1:0] random_half();
		logic [HALF_W-1:0] h;
		for (int k = 0; k < HALF_W / 32; k++)
			h[k*32 +: 32] = $random(seed);
		return h;
	endfunction

	wr_engine #(
		.BUF_DEPTH       (BUF_DEPTH),
		.CMD_CREDITS     (CMD_CREDITS),
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) wr_engine_i (
		.clock       (clock),
		.rstn        (rstn),
		.job         (job),
		.data_in     (data_in),
		.cmd_credit  (cmd_credit),
		.resp_in     (resp_in),
		.data_credit (data_credit),
		.cmd_out     (cmd_out),
		.line_out    (line_out),
		.job_busy    (job_busy),
		.job_done    (job_done),
		.lines_done  (lines_done)
	);

	tb_wr_checker #(
		.NUM_JOBS (NUM_JOBS)
	) checker_i (
		.clock       (clock),
		.rstn        (rstn),
		.data_in     (data_in),
		.exp_cmd     (exp_cmd),
		.data_credit (data_credit),
		.cmd_out     (cmd_out),
		.line_out    (line_out),
		.resp_in     (resp_in),
		.job_busy    (job_busy),
		.job_done    (job_done),
		.lines_done  (lines_done),
		.report      (report),
		.errors      (errors)
	);

	bind wr_engine wr_engine_assert #(
		.BUF_DEPTH       (BUF_DEPTH),
		.CMD_CREDITS     (CMD_CREDITS),
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) assert_i (
		.clock       (clock),
		.rstn        (rstn),
		.data_in     (data_in),
		.data_credit (data_credit),
		.cmd_out     (cmd_out),
		.cmd_credit  (cmd_credit),
		.resp_in     (resp_in),
		.job_done    (job_done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog: no finish after %0d cycles, the engine stopped", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	////////////////////
	// producer, responses, credits
	////////////////////

	// one item per cycle while a data credit is held
	always @(negedge clock) begin
		if (data_credit)
			credits = credits + 1;
		if (rstn && item_q.size() > 0 && credits > 0) begin
			data_in <= item_q.pop_front();
			exp_cmd <= ref_q.pop_front();
			credits = credits - 1;
		end else begin
			data_in <= '0;
			exp_cmd <= '0;
		end
	end

	always @(negedge clock) begin
		int       delay;
		wr_resp_t r;
		r = '0;
		if (cmd_out.valid) begin
			delay = $unsigned($random(resp_seed)) % 6 + 1;
			resp_due.push_back(cycle + delay);
			resp_lines.push_back(cmd_out.lines);
		end
		if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
			r.valid = 1'b1;
			r.lines = resp_lines.pop_front();
			void'(resp_due.pop_front());
		end
		resp_in <= r;
	end

	// held back while credit_pause is set
	always @(negedge clock) begin
		int delay;
		if (cmd_out.valid) begin
			delay = $unsigned($random(credit_seed)) % 8 + 1;
			credit_due.push_back(cycle + delay);
		end
		if (!credit_pause && credit_due.size() > 0 && credit_due[0] <= cycle) begin
			cmd_credit <= 1'b1;
			void'(credit_due.pop_front());
		end else begin
			cmd_credit <= 1'b0;
		end
	end

	task automatic run_job(input logic [ADDR_W-1:0] base, input int len, input logic mode,
			input logic pause);
		wr_job_t  j;
		wr_data_t d;
		int       left;
		int       offset;
		int       size;
		j = '0;
		j.valid = 1'b1;
		j.base = base;
		j.len = LEN_W'(len);
		j.mode = mode;
		@(negedge clock);
		job <= j;
		@(negedge clock);
		job <= '0;
		@(posedge clock);
		if (pause)
			credit_pause = 1'b1;
		left = len;
		offset = 0;
		// consecutive offsets, sizes trimmed to the job length
		while (left > 0) begin
			size = $unsigned($random(seed)) % 4 + 1;
			if (size > left)
				size = left;
			d = '0;
			d.valid = 1'b1;
			d.offset = LEN_W'(offset);
			d.size = SIZE_W'(size);
			d.half0 = random_half();
			d.half1 = random_half();
			item_q.push_back(d);
			ref_q.push_back(expect_cmd(j, d));
			offset = offset + size;
			left = left - size;
		end
		if (pause) begin
			repeat (PAUSE_CYCLES) @(posedge clock);
			credit_pause = 1'b0;
		end
		do
			@(negedge clock);
		while (!job_done);
		repeat (3) @(negedge clock);
	endtask

	initial begin
		job = '0;
		report = 1'b0;
		rstn = 1'b0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rstn <= 1'b1;
		run_job(64'h0000_0012_3456_0000, 37, 1'b1, 1'b0);
		run_job(64'h0000_0040_0000_0400, 29, 1'b0, 1'b0);
		run_job(64'h0000_0001_0000_0080, 24, 1'b1, 1'b1);
		@(negedge clock);
		report <= 1'b1;
		@(negedge clock);
		report <= 1'b0;
		@(negedge clock);
		if (errors == 0 && wr_engine_i.assert_i.fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- tb_wr_checker.sv
////////////////////
// compares engine commands and lines with the expected stream, in order
// one line per job, then a credit balance test and a closing count line
////////////////////

`timescale 1ns/1ps

module tb_wr_checker #(
	parameter int NUM_JOBS = 3
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  wr_cmd_pkg::wr_data_t         data_in,
	input  wr_cmd_pkg::wr_cmd_t          exp_cmd,
	input  logic                         data_credit,
	input  wr_cmd_pkg::wr_cmd_t          cmd_out,
	input  wr_cmd_pkg::wr_line_t         line_out,
	input  wr_cmd_pkg::wr_resp_t         resp_in,
	input  logic                         job_busy,
	input  logic                         job_done,
	input  logic [wr_cfg_pkg::LEN_W-1:0] lines_done,
	input  logic                         report,
	output int                           errors
);

	import wr_cfg_pkg::*;
	import wr_cmd_pkg::*;

	wr_cmd_t           exp_q[$];
	logic [HALF_W-1:0] half0_q[$];
	logic [HALF_W-1:0] half1_q[$];
	logic [LEN_W-1:0]  lines_sum = '0;
	string             test_name = "job0";
	int                job_idx = 0;
	int                job_errors = 0;
	int                job_cmds = 0;
	int                job_resps = 0;
	int                pushed = 0;
	int                returned = 0;
	int                done_count = 0;
	int                passed = 0;
	logic              done_q = 1'b0;

	initial errors = 0;

	task automatic value_error(input string what, input logic [HALF_W-1:0] want,
			input logic [HALF_W-1:0] got);
		$display("Fail %s %s: expected %0h, actual %0h", test_name, what, want, got);
		errors++;
		job_errors++;
	endtask

	task automatic other_error(input string msg);
		$display("Error in %s: %s", test_name, msg);
		errors++;
		job_errors++;
	endtask

	task automatic compare_cmd();
		wr_cmd_t           want;
		logic [HALF_W-1:0] h0;
		logic [HALF_W-1:0] h1;
		if (exp_q.size() == 0) begin
			other_error("command issued with no pending item");
		end else begin
			want = exp_q.pop_front();
			h0 = half0_q.pop_front();
			h1 = half1_q.pop_front();
			if (cmd_out.op != want.op)
				value_error("opcode", HALF_W'(want.op), HALF_W'(cmd_out.op));
			if (cmd_out.addr != want.addr)
				value_error("address", HALF_W'(want.addr), HALF_W'(cmd_out.addr));
			if (cmd_out.bytes != want.bytes)
				value_error("byte size", HALF_W'(want.bytes), HALF_W'(cmd_out.bytes));
			if (cmd_out.lines != want.lines)
				value_error("line count", HALF_W'(want.lines), HALF_W'(cmd_out.lines));
			// data must ride in the same cycle as its command
			if (!line_out.valid)
				other_error("data line missing in the command cycle");
			if (line_out.half0 != h0)
				value_error("half0", h0, line_out.half0);
			if (line_out.half1 != h1)
				value_error("half1", h1, line_out.half1);
		end
		job_cmds++;
	endtask

	task automatic close_job();
		if (job_resps != job_cmds)
			other_error("job_done before the last response returned");
		if (exp_q.size() != 0)
			other_error("job_done with items still waiting in the engine");
		if (lines_done != lines_sum)
			value_error("lines_done", HALF_W'(lines_sum), HALF_W'(lines_done));
		if (!job_busy)
			other_error("job_busy low in the job_done cycle");
		if (job_errors == 0)
			passed++;
		$display("%s: %0d commands, %0d responses, lines_done %0d, %0d errors",
			test_name, job_cmds, job_resps, lines_done, job_errors);
		done_count++;
		job_idx++;
		test_name = $sformatf("job%0d", job_idx);
		job_errors = 0;
		job_cmds = 0;
		job_resps = 0;
	endtask

	task automatic close_run();
		test_name = "credits";
		job_errors = 0;
		if (done_count != NUM_JOBS)
			value_error("job_done pulses", HALF_W'(NUM_JOBS), HALF_W'(done_count));
		if (returned != pushed)
			value_error("data credits returned", HALF_W'(pushed), HALF_W'(returned));
		if (exp_q.size() != 0)
			other_error("items pushed but never issued");
		if (job_errors == 0)
			passed++;
		$display("%s: %0d items pushed, %0d data credits returned, %0d errors",
			test_name, pushed, returned, job_errors);
		$display("summary: %0d tests, %0d passed, %0d errors", NUM_JOBS + 1, passed, errors);
	endtask

	////////////////////
	// monitor
	////////////////////

	always @(posedge clock) begin
		if (rstn) begin
			if (data_in.valid) begin
				exp_q.push_back(exp_cmd);
				half0_q.push_back(data_in.half0);
				half1_q.push_back(data_in.half1);
				lines_sum = lines_sum + LEN_W'(data_in.size);
				pushed++;
			end
			if (data_credit)
				returned++;
			if (cmd_out.valid) begin
				if (!job_busy)
					other_error("command issued while job_busy was low");
				compare_cmd();
			end
			if (resp_in.valid)
				job_resps++;
			// engine is back in idle the cycle after job_done
			if (done_q && job_busy)
				other_error("job_busy still high after the previous job_done");
			if (job_done) begin
				if (done_q)
					other_error("job_done high for more than one cycle");
				else
					close_job();
			end
			done_q = job_done;
			if (report)
				close_run();
		end
	end

endmodule

//--- wr_engine_assert.sv
////////////////////
// credit and window assertions, bound to the write engine
// counters follow the engine ports and assume one response per command
////////////////////

`timescale 1ns/1ps

module wr_engine_assert #(
	parameter int BUF_DEPTH       = 8,
	parameter int CMD_CREDITS     = 4,
	parameter int MAX_OUTSTANDING = 6
) (
	input logic                 clock,
	input logic                 rstn,
	input wr_cmd_pkg::wr_data_t data_in,
	input logic                 data_credit,
	input wr_cmd_pkg::wr_cmd_t  cmd_out,
	input logic                 cmd_credit,
	input wr_cmd_pkg::wr_resp_t resp_in,
	input logic                 job_done
);

	int prod_credits;
	int in_flight;
	int outstanding;
	int fail_count = 0;

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prod_credits <= BUF_DEPTH;
			in_flight    <= 0;
			outstanding  <= 0;
		end else begin
			prod_credits <= prod_credits - int'(data_in.valid) + int'(data_credit);
			in_flight    <= in_flight + int'(cmd_out.valid) - int'(cmd_credit);
			outstanding  <= outstanding + int'(cmd_out.valid) - int'(resp_in.valid);
		end
	end

	////////////////////
	// producer credits
	////////////////////

	// a credit pulse may be spent in the cycle it is seen
	producer_has_credit: assert property (@(posedge clock) disable iff (!rstn)
		data_in.valid |-> prod_credits + int'(data_credit) > 0)
		else begin
			fail_count++;
			$error("item pushed while the producer held no data credit");
		end

	credits_not_over_returned: assert property (@(posedge clock) disable iff (!rstn)
		prod_credits <= BUF_DEPTH)
		else begin
			fail_count++;
			$error("more data credits returned than items pushed");
		end

	////////////////////
	// command credits and window
	////////////////////

	cmd_credit_limit: assert property (@(posedge clock) disable iff (!rstn)
		in_flight <= CMD_CREDITS)
		else begin
			fail_count++;
			$error("commands in flight exceed the command credits");
		end

	window_limit: assert property (@(posedge clock) disable iff (!rstn)
		outstanding <= MAX_OUTSTANDING && outstanding >= 0)
		else begin
			fail_count++;
			$error("commands without a response outside the window limit");
		end

	// all responses are back when the job ends
	done_after_last_resp: assert property (@(posedge clock) disable iff (!rstn)
		job_done |-> outstanding == 0)
		else begin
			fail_count++;
			$error("job_done raised while responses were still missing");
		end

endmodule

//--- wr_engine.sv
////////////////////
// write engine top: buffer, job control, command issue
// producer starts with BUF_DEPTH data credits, issue with CMD_CREDITS
// responses are always accepted
////////////////////

`timescale 1ns/1ps

module wr_engine #(
	parameter int BUF_DEPTH       = 8,
	parameter int CMD_CREDITS     = 4,
	parameter int MAX_OUTSTANDING = 6
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  wr_cmd_pkg::wr_job_t          job,
	input  wr_cmd_pkg::wr_data_t         data_in,
	input  logic                         cmd_credit,
	input  wr_cmd_pkg::wr_resp_t         resp_in,
	output logic                         data_credit,
	output wr_cmd_pkg::wr_cmd_t          cmd_out,
	output wr_cmd_pkg::wr_line_t         line_out,
	output logic                         job_busy,
	output logic                         job_done,
	output logic [wr_cfg_pkg::LEN_W-1:0] lines_done
);

	import wr_cfg_pkg::*;
	import wr_cmd_pkg::*;

	wr_data_t         head;
	logic             head_valid;
	logic             pop;
	logic             issue_en;
	wr_job_t          job_base;
	logic             sent;
	logic [LEN_W-1:0] remaining;

	wr_data_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) buffer_i (
		.clock       (clock),
		.rstn        (rstn),
		.data_in     (data_in),
		.pop         (pop),
		.head        (head),
		.head_valid  (head_valid),
		.data_credit (data_credit)
	);

	wr_job_ctrl #(
		.MAX_OUTSTANDING (MAX_OUTSTANDING)
	) job_ctrl_i (
		.clock      (clock),
		.rstn       (rstn),
		.job        (job),
		.sent       (sent),
		.remaining  (remaining),
		.resp_in    (resp_in),
		.issue_en   (issue_en),
		.job_base   (job_base),
		.job_busy   (job_busy),
		.job_done   (job_done),
		.lines_done (lines_done)
	);

	wr_cmd_issue #(
		.CMD_CREDITS (CMD_CREDITS)
	) cmd_issue_i (
		.clock      (clock),
		.rstn       (rstn),
		.head       (head),
		.head_valid (head_valid),
		.issue_en   (issue_en),
		.job_base   (job_base),
		.cmd_credit (cmd_credit),
		.pop        (pop),
		.sent       (sent),
		.remaining  (remaining),
		.cmd_out    (cmd_out),
		.line_out   (line_out)
	);

endmodule

//--- wr_cmd_issue.sv
////////////////////
// issues one write command and one data line per buffered item
// no command leaves without a command credit
// address = base + offset * 128, byte size = lines * 128
////////////////////

`timescale 1ns/1ps

module wr_cmd_issue #(
	parameter int CMD_CREDITS = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  wr_cmd_pkg::wr_data_t         head,
	input  logic                         head_valid,
	input  logic                         issue_en,
	input  wr_cmd_pkg::wr_job_t          job_base,
	input  logic                         cmd_credit,
	output logic                         pop,
	output logic                         sent,
	output logic [wr_cfg_pkg::LEN_W-1:0] remaining,
	output wr_cmd_pkg::wr_cmd_t          cmd_out,
	output wr_cmd_pkg::wr_line_t         line_out
);

	import wr_cfg_pkg::*;
	import wr_cmd_pkg::*;

	logic [CNT_W-1:0] credits;
	logic             has_credit;
	logic             out_valid;
	wr_cmd_t          cmd_nxt;
	wr_cmd_t          cmd_q;
	wr_line_t         line_q;

	assign has_credit = (credits != '0);
	assign pop = head_valid && issue_en && has_credit;
	assign sent = pop;

	////////////////////
	// command credits
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			credits <= CNT_W'(CMD_CREDITS);
		else
			credits <= credits + CNT_W'(cmd_credit) - CNT_W'(pop);
	end

	////////////////////
	// command build
	////////////////////

	always_comb begin
		cmd_nxt = '0;
		cmd_nxt.valid = 1'b1;
		// mode bit picks ownership or no-allocate write
		cmd_nxt.op = job_base.mode ? op_write_ms : op_write_na;
		cmd_nxt.addr = job_base.base + ADDR_W'(head.offset) * ADDR_W'(LINE_BYTES);
		cmd_nxt.bytes = BYTES_W'(head.size) * BYTES_W'(LINE_BYTES);
		cmd_nxt.lines = head.size;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			out_valid <= 1'b0;
		else
			out_valid <= pop;
	end

	// command and data payload, loaded together
	always_ff @(posedge clock) begin
		if (pop) begin
			cmd_q        <= cmd_nxt;
			line_q.valid <= 1'b1;
			line_q.half0 <= head.half0;
			line_q.half1 <= head.half1;
		end
	end

	always_comb begin
		cmd_out = cmd_q;
		cmd_out.valid = out_valid;
		line_out = line_q;
		line_out.valid = out_valid;
	end

	////////////////////
	// remaining lines of the job
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			remaining <= '0;
		else if (job_base.valid)
			remaining <= job_base.len;
		else if (pop)
			remaining <= remaining - LEN_W'(head.size);
	end

endmodule

//--- wr_job_ctrl.sv
////////////////////
// job FSM: one job at a time, a job pulse outside idle is ignored
// at most MAX_OUTSTANDING commands per window, then waits for all responses
// job_base.valid is high only in the cycle after acceptance
////////////////////

`timescale 1ns/1ps

module wr_job_ctrl #(
	parameter int MAX_OUTSTANDING = 6
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  wr_cmd_pkg::wr_job_t          job,
	input  logic                         sent,
	input  logic [wr_cfg_pkg::LEN_W-1:0] remaining,
	input  wr_cmd_pkg::wr_resp_t         resp_in,
	output logic                         issue_en,
	output wr_cmd_pkg::wr_job_t          job_base,
	output logic                         job_busy,
	output logic                         job_done,
	output logic [wr_cfg_pkg::LEN_W-1:0] lines_done
);

	import wr_cfg_pkg::*;
	import wr_cmd_pkg::*;

	wr_state_e        state;
	wr_state_e        state_nxt;
	logic [CNT_W-1:0] send_cnt;
	logic [CNT_W-1:0] resp_cnt;
	logic             accept;
	logic             win_open;
	logic             load_q;
	wr_job_t          job_q;

	assign accept = (state == st_idle) && job.valid;

	// window still has room and the job still has lines
	assign win_open = (send_cnt < CNT_W'(MAX_OUTSTANDING)) && (remaining != '0);

	assign issue_en = (state == st_req) && win_open;
	assign job_busy = (state != st_idle);
	assign job_done = (state == st_done) && (remaining == '0);

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (accept)
					state_nxt = st_start;
			end
			st_start: begin
				state_nxt = st_req;
			end
			st_req: begin
				if (!win_open)
					state_nxt = st_pending;
			end
			st_pending: begin
				// last response of the window is in
				if (resp_cnt == send_cnt)
					state_nxt = st_done;
			end
			st_done: begin
				if (remaining == '0)
					state_nxt = st_idle;
				else
					state_nxt = st_start;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	////////////////////
	// window counts
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			send_cnt <= '0;
			resp_cnt <= '0;
		end else if (state == st_start) begin
			send_cnt <= '0;
			resp_cnt <= '0;
		end else begin
			if (sent)
				send_cnt <= send_cnt + 1'b1;
			if (resp_in.valid)
				resp_cnt <= resp_cnt + 1'b1;
		end
	end

	// completed lines, kept across jobs
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			lines_done <= '0;
		else if (resp_in.valid)
			lines_done <= lines_done + LEN_W'(resp_in.lines);
	end

	////////////////////
	// job latch
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			load_q <= 1'b0;
		else
			load_q <= accept;
	end

	always_ff @(posedge clock) begin
		if (accept)
			job_q <= job;
	end

	// valid marks the load cycle for the issue stage
	always_comb begin
		job_base = job_q;
		job_base.valid = load_q;
	end

endmodule

//--- wr_data_buffer.sv
////////////////////
// item FIFO in front of the command issue stage
// no full flag: the producer may push only while it holds a data credit
// one data credit goes back the cycle after each pop
////////////////////

`timescale 1ns/1ps

module wr_data_buffer #(
	parameter int BUF_DEPTH = 8
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  wr_cmd_pkg::wr_data_t data_in,
	input  logic                 pop,
	output wr_cmd_pkg::wr_data_t head,
	output logic                 head_valid,
	output logic                 data_credit
);

	import wr_cmd_pkg::*;

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int FILL_W = $clog2(BUF_DEPTH + 1);

	wr_data_t          mem [BUF_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [FILL_W-1:0] fill;
	logic              push;
	logic              take;

	assign push = data_in.valid;
	assign take = pop && head_valid;
	assign head_valid = (fill != '0);

	// head reads straight from storage
	always_comb begin
		head = mem[rd_ptr];
		head.valid = head_valid;
	end

	////////////////////
	// storage
	////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	////////////////////
	// pointers and fill level
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push) begin
				// wrap for any depth
				if (wr_ptr == PTR_W'(BUF_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (take) begin
				if (rd_ptr == PTR_W'(BUF_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			fill <= fill + FILL_W'(push) - FILL_W'(take);
		end
	end

	// credit back to the producer
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			data_credit <= 1'b0;
		else
			data_credit <= take;
	end

endmodule

//--- wr_cmd_pkg.sv
////////////////////
// job, data, command and response types of the write engine
// every command uses strict ordering, so no ordering field is carried
////////////////////

package wr_cmd_pkg;

	import wr_cfg_pkg::*;

	// write opcodes
	typedef enum logic [1:0] {
		op_write_ms = 2'b01,
		op_write_na = 2'b10
	} wr_op_e;

	// job control states
	typedef enum logic [2:0] {
		st_idle    = 3'd0,
		st_start   = 3'd1,
		st_req     = 3'd2,
		st_pending = 3'd3,
		st_done    = 3'd4
	} wr_state_e;

	// mode set selects write with ownership
	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] base;
		logic [LEN_W-1:0]  len;
		logic              mode;
	} wr_job_t;

	// one item: line offset within the job, size in lines, two halves
	typedef struct packed {
		logic              valid;
		logic [LEN_W-1:0]  offset;
		logic [SIZE_W-1:0] size;
		logic [HALF_W-1:0] half0;
		logic [HALF_W-1:0] half1;
	} wr_data_t;

	typedef struct packed {
		logic               valid;
		wr_op_e             op;
		logic [ADDR_W-1:0]  addr;
		logic [BYTES_W-1:0] bytes;
		logic [SIZE_W-1:0]  lines;
	} wr_cmd_t;

	typedef struct packed {
		logic              valid;
		logic [HALF_W-1:0] half0;
		logic [HALF_W-1:0] half1;
	} wr_line_t;

	typedef struct packed {
		logic              valid;
		logic [SIZE_W-1:0] lines;
	} wr_resp_t;

endpackage

//--- wr_cfg_pkg.sv
////////////////////
// widths and sizes shared by the write engine
// line size is fixed at 128 bytes, so one command moves at most 512 bytes
// CNT_W must hold BUF_DEPTH, CMD_CREDITS and MAX_OUTSTANDING
////////////////////

package wr_cfg_pkg;

	// address and job length
	localparam int ADDR_W = 64;
	localparam int LEN_W = 32;

	// one cache line is carried as two halves
	localparam int HALF_W = 512;
	localparam int LINE_BYTES = 128;

	// item size in lines, 1 to 4
	localparam int SIZE_W = 3;

	// command byte size field
	localparam int BYTES_W = 12;

	// credit and window counters
	localparam int CNT_W = 16;

endpackage
